/* logic/world_pkg.sv */
`default_nettype none

package world_pkg;

    // playfield coordinates
    localparam int X_W = 10;
    localparam int Y_W = 9;

    typedef logic [X_W-1:0] pos_x_t;
    typedef logic [Y_W-1:0] pos_y_t;

    // player box whose top-left corner is the position
    localparam int PLAYER_W = 16;
    localparam int PLAYER_H = 16;

    // standing on the first floor block
    localparam pos_x_t START_X = 10'd0;
    localparam pos_y_t START_Y = 9'd384;

    // five floor blocks then three platforms
    localparam int GROUND_NUM = 8;
    localparam int BLOCK_W    = 32;
    localparam int BLOCK_H    = 16;

    localparam pos_x_t GROUND_X [GROUND_NUM] = '{
        0, 32, 64, 96, 128, 176, 208, 272
    };
    localparam pos_y_t GROUND_Y [GROUND_NUM] = '{
        400, 400, 400, 400, 400, 340, 340, 340
    };

    // three snowflakes on the floor and three on the platforms
    localparam int FLAKE_NUM = 6;
    localparam int FLAKE_W   = 8;
    localparam int FLAKE_H   = 8;

    localparam pos_x_t FLAKE_X [FLAKE_NUM] = '{
        40, 88, 136, 180, 220, 280
    };
    localparam pos_y_t FLAKE_Y [FLAKE_NUM] = '{
        388, 388, 388, 324, 324, 324
    };

    // wide enough to count every flake
    localparam int SCORE_W = 3;

endpackage

`default_nettype wire

/* logic/ctrl_pkg.sv */
`default_nettype none

package ctrl_pkg;

    // PS/2 set 2 scan codes
    localparam int SCAN_W = 8;

    localparam logic [SCAN_W-1:0] KEY_W        = 8'h1D;
    localparam logic [SCAN_W-1:0] KEY_A        = 8'h1C;
    localparam logic [SCAN_W-1:0] KEY_D        = 8'h23;
    localparam logic [SCAN_W-1:0] KEY_R        = 8'h2D;
    localparam logic [SCAN_W-1:0] BREAK_PREFIX = 8'hF0;

    // held-key flag positions
    localparam int KEY_NUM    = 3;
    localparam int HELD_JUMP  = 0;
    localparam int HELD_LEFT  = 1;
    localparam int HELD_RIGHT = 2;

    // motion pacing
    localparam int STEP_DIV   = 8;
    localparam int STEP_CNT_W = $clog2(STEP_DIV);
    localparam int JUMP_STEPS = 24;
    localparam int JUMP_CNT_W = $clog2(JUMP_STEPS + 1);

    // bit positions in the blocked-side vector
    localparam int BLK_DOWN  = 0;
    localparam int BLK_UP    = 1;
    localparam int BLK_RIGHT = 2;
    localparam int BLK_LEFT  = 3;

endpackage

`default_nettype wire

/* logic/key_decoder.sv */
`default_nettype none

module key_decoder (
    input  wire logic                         clk,
    input  wire logic                         rst_n_i,
    input  wire logic                         scan_valid_i,
    input  wire logic [ctrl_pkg::SCAN_W-1:0]  scan_code_i,
    output logic      [ctrl_pkg::KEY_NUM-1:0] keys_held_o,
    output logic                              restart_o
);

    import ctrl_pkg::*;

    // set by F0 and consumed by whatever byte follows
    logic break_armed;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            break_armed <= 1'b0;
            keys_held_o <= '0;
            restart_o   <= 1'b0;
        end else begin
            // restart is a single-cycle pulse
            restart_o <= 1'b0;
            if (scan_valid_i) begin
                break_armed <= 1'b0;
                case (scan_code_i)
                    BREAK_PREFIX: begin
                        break_armed <= 1'b1;
                    end
                    // make sets the flag and break clears it
                    KEY_W: begin
                        keys_held_o[HELD_JUMP] <= !break_armed;
                    end
                    KEY_A: begin
                        keys_held_o[HELD_LEFT] <= !break_armed;
                    end
                    KEY_D: begin
                        keys_held_o[HELD_RIGHT] <= !break_armed;
                    end
                    KEY_R: begin
                        // only the make code restarts
                        restart_o <= !break_armed;
                    end
                    default: begin
                        // unknown codes just drop a pending break
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* logic/ground_collide.sv */
`default_nettype none

module ground_collide (
    input  wire logic              clk,
    input  wire logic              rst_n_i,
    input  wire world_pkg::pos_x_t pos_x_i,
    input  wire world_pkg::pos_y_t pos_y_i,
    output logic [3:0]             blocked_o
);

    import world_pkg::*;
    import ctrl_pkg::*;

    wire [GROUND_NUM-1:0] down_hit;
    wire [GROUND_NUM-1:0] up_hit;
    wire [GROUND_NUM-1:0] right_hit;
    wire [GROUND_NUM-1:0] left_hit;

    // one set of adjacency tests per block
    for (genvar g = 0; g < GROUND_NUM; g++) begin : g_block
        localparam int BX = int'(GROUND_X[g]);
        localparam int BY = int'(GROUND_Y[g]);

        // corner contact counts for vertical tests, so a diagonal
        // step can never cut into a block corner
        wire x_touch = (int'(pos_x_i) <= BX + BLOCK_W) &&
                       (int'(pos_x_i) + PLAYER_W >= BX);
        wire y_overlap = (int'(pos_y_i) < BY + BLOCK_H) &&
                         (int'(pos_y_i) + PLAYER_H > BY);

        assign down_hit[g]  = (int'(pos_y_i) + PLAYER_H == BY) && x_touch;
        assign up_hit[g]    = (int'(pos_y_i) == BY + BLOCK_H) && x_touch;
        assign right_hit[g] = (int'(pos_x_i) + PLAYER_W == BX) && y_overlap;
        assign left_hit[g]  = (int'(pos_x_i) == BX + BLOCK_W) && y_overlap;
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            // start position rests on the floor
            blocked_o           <= '0;
            blocked_o[BLK_DOWN] <= 1'b1;
        end else begin
            blocked_o[BLK_DOWN]  <= |down_hit;
            blocked_o[BLK_UP]    <= |up_hit;
            blocked_o[BLK_RIGHT] <= |right_hit;
            blocked_o[BLK_LEFT]  <= |left_hit;
        end
    end

endmodule

`default_nettype wire

/* logic/player_motion.sv */
`default_nettype none

module player_motion (
    input  wire logic                         clk,
    input  wire logic                         rst_n_i,
    input  wire logic [ctrl_pkg::KEY_NUM-1:0] keys_held_i,
    input  wire logic                         restart_i,
    input  wire logic [3:0]                   blocked_i,
    output world_pkg::pos_x_t                 pos_x_o,
    output world_pkg::pos_y_t                 pos_y_o,
    output logic                              airborne_o,
    output logic                              facing_right_o
);

    import ctrl_pkg::*;
    import world_pkg::*;

    logic [STEP_CNT_W-1:0] step_cnt;
    logic                  step_tick;
    logic                  jumping;
    logic [JUMP_CNT_W-1:0] jump_cnt;
    logic                  move_left;
    logic                  move_right;

    assign step_tick = (step_cnt == STEP_CNT_W'(STEP_DIV - 1));

    // left wins only when right is not also held
    assign move_left  = keys_held_i[HELD_LEFT] && !keys_held_i[HELD_RIGHT] &&
                        !blocked_i[BLK_LEFT];
    assign move_right = keys_held_i[HELD_RIGHT] && !blocked_i[BLK_RIGHT];

    assign airborne_o = !blocked_i[BLK_DOWN];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            step_cnt <= '0;
        end else if (restart_i || step_tick) begin
            step_cnt <= '0;
        end else begin
            step_cnt <= step_cnt + 1'b1;
        end
    end

    // walking
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pos_x_o        <= START_X;
            facing_right_o <= 1'b1;
        end else if (restart_i) begin
            pos_x_o <= START_X;
        end else if (step_tick) begin
            if (move_left) begin
                pos_x_o        <= pos_x_o - 1'b1;
                facing_right_o <= 1'b0;
            end else if (move_right) begin
                pos_x_o        <= pos_x_o + 1'b1;
                facing_right_o <= 1'b1;
            end
        end
    end

    // jump and fall
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pos_y_o  <= START_Y;
            jumping  <= 1'b0;
            jump_cnt <= '0;
        end else if (restart_i) begin
            pos_y_o  <= START_Y;
            jumping  <= 1'b0;
            jump_cnt <= '0;
        end else if (step_tick) begin
            if (jumping) begin
                // rise is cut short by a ceiling
                if (blocked_i[BLK_UP] || jump_cnt == JUMP_CNT_W'(JUMP_STEPS)) begin
                    jumping <= 1'b0;
                    if (!blocked_i[BLK_DOWN]) begin
                        pos_y_o <= pos_y_o + 1'b1;
                    end
                end else begin
                    pos_y_o  <= pos_y_o - 1'b1;
                    jump_cnt <= jump_cnt + 1'b1;
                end
            end else if (keys_held_i[HELD_JUMP] && blocked_i[BLK_DOWN]) begin
                jumping  <= 1'b1;
                jump_cnt <= '0;
            end else if (!blocked_i[BLK_DOWN]) begin
                pos_y_o <= pos_y_o + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* logic/flake_collect.sv */
`default_nettype none

module flake_collect (
    input  wire logic                            clk,
    input  wire logic                            rst_n_i,
    input  wire world_pkg::pos_x_t               pos_x_i,
    input  wire world_pkg::pos_y_t               pos_y_i,
    output logic [world_pkg::FLAKE_NUM-1:0]      flakes_taken_o,
    output logic [world_pkg::SCORE_W-1:0]        score_o
);

    import world_pkg::*;

    wire  [FLAKE_NUM-1:0] touching;
    logic [FLAKE_NUM-1:0] new_taken;

    // box overlap with each flake
    for (genvar f = 0; f < FLAKE_NUM; f++) begin : g_flake
        localparam int FX = int'(FLAKE_X[f]);
        localparam int FY = int'(FLAKE_Y[f]);

        assign touching[f] = (int'(pos_x_i) < FX + FLAKE_W) &&
                             (int'(pos_x_i) + PLAYER_W > FX) &&
                             (int'(pos_y_i) < FY + FLAKE_H) &&
                             (int'(pos_y_i) + PLAYER_H > FY);
    end

    // each flake scores once
    assign new_taken = touching & ~flakes_taken_o;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            flakes_taken_o <= '0;
            score_o        <= '0;
        end else begin
            flakes_taken_o <= flakes_taken_o | new_taken;
            score_o        <= score_o + SCORE_W'($countones(new_taken));
        end
    end

endmodule

`default_nettype wire

/* logic/snow_game_top.sv */
`default_nettype none

module snow_game_top (
    input  wire logic                            clk,
    input  wire logic                            rst_n_i,
    input  wire logic                            scan_valid_i,
    input  wire logic [ctrl_pkg::SCAN_W-1:0]     scan_code_i,
    output world_pkg::pos_x_t                    pos_x_o,
    output world_pkg::pos_y_t                    pos_y_o,
    output logic                                 airborne_o,
    output logic                                 facing_right_o,
    output logic [world_pkg::SCORE_W-1:0]        score_o,
    output logic [world_pkg::FLAKE_NUM-1:0]      flakes_taken_o
);

    logic [ctrl_pkg::KEY_NUM-1:0] keys_held;
    logic                         restart;
    world_pkg::pos_x_t            pos_x;
    world_pkg::pos_y_t            pos_y;
    logic [3:0]                   blocked;

    assign pos_x_o = pos_x;
    assign pos_y_o = pos_y;

    key_decoder u_key_decoder (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .scan_valid_i (scan_valid_i),
        .scan_code_i  (scan_code_i),
        .keys_held_o  (keys_held),
        .restart_o    (restart)
    );

    // collision result lags position by one cycle
    ground_collide u_ground_collide (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .pos_x_i   (pos_x),
        .pos_y_i   (pos_y),
        .blocked_o (blocked)
    );

    player_motion u_player_motion (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .keys_held_i    (keys_held),
        .restart_i      (restart),
        .blocked_i      (blocked),
        .pos_x_o        (pos_x),
        .pos_y_o        (pos_y),
        .airborne_o     (airborne_o),
        .facing_right_o (facing_right_o)
    );

    flake_collect u_flake_collect (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .pos_x_i        (pos_x),
        .pos_y_i        (pos_y),
        .flakes_taken_o (flakes_taken_o),
        .score_o        (score_o)
    );

endmodule

`default_nettype wire

/* dv/game_checker.sv */
`default_nettype none

module game_checker (
    input  wire logic                             clk,
    input  wire logic                             rst_n_i,
    input  wire logic                             scan_valid_i,
    input  wire logic [ctrl_pkg::SCAN_W-1:0]      scan_code_i,
    input  wire world_pkg::pos_x_t                pos_x_i,
    input  wire world_pkg::pos_y_t                pos_y_i,
    input  wire logic                             airborne_i,
    input  wire logic                             facing_right_i,
    input  wire logic [world_pkg::SCORE_W-1:0]    score_i,
    input  wire logic [world_pkg::FLAKE_NUM-1:0]  flakes_taken_i,
    input  wire logic                             done_i,
    output int                                    mismatch_cnt_o,
    output int                                    other_cnt_o
);

    timeunit 1ns;
    timeprecision 100ps;

    import world_pkg::*;
    import ctrl_pkg::*;

    // model of the state the DUT holds after the last rising edge
    logic                 brk_m;
    logic                 rst_m;
    logic [KEY_NUM-1:0]   held_m;
    int                   cnt_m;
    pos_x_t               x_m;
    pos_y_t               y_m;
    logic                 face_m;
    logic                 jump_m;
    int                   jcnt_m;
    logic [3:0]           blk_m;
    logic [FLAKE_NUM-1:0] mask_m;
    logic                 stepped_m;
    logic                 restarted_m;

    pos_x_t     x_prev;
    pos_y_t     y_prev;
    pos_x_t     dx;
    pos_y_t     dy;
    int         rise_run;
    logic       tick;
    logic [3:0] sides_now;

    // vertical contact also counts at a block corner
    function automatic logic [3:0] sides_at(input int x, input int y);
        logic [3:0] s;
        int         bx;
        int         by;
        logic       near_x;
        logic       over_y;
        s = '0;
        for (int b = 0; b < GROUND_NUM; b++) begin
            bx     = GROUND_X[b];
            by     = GROUND_Y[b];
            near_x = (x + PLAYER_W >= bx) && (x <= bx + BLOCK_W);
            over_y = (y + PLAYER_H > by) && (y < by + BLOCK_H);
            s[BLK_DOWN]  |= near_x && (y + PLAYER_H == by);
            s[BLK_UP]    |= near_x && (y == by + BLOCK_H);
            s[BLK_RIGHT] |= over_y && (x + PLAYER_W == bx);
            s[BLK_LEFT]  |= over_y && (x == bx + BLOCK_W);
        end
        return s;
    endfunction

    function automatic logic hits_ground(input int x, input int y);
        logic hit;
        hit = 1'b0;
        for (int b = 0; b < GROUND_NUM; b++) begin
            hit |= (x < GROUND_X[b] + BLOCK_W) && (x + PLAYER_W > GROUND_X[b]) &&
                   (y < GROUND_Y[b] + BLOCK_H) && (y + PLAYER_H > GROUND_Y[b]);
        end
        return hit;
    endfunction

    function automatic logic [FLAKE_NUM-1:0] flakes_under(input int x, input int y);
        logic [FLAKE_NUM-1:0] m;
        for (int f = 0; f < FLAKE_NUM; f++) begin
            m[f] = (x < FLAKE_X[f] + FLAKE_W) && (x + PLAYER_W > FLAKE_X[f]) &&
                   (y < FLAKE_Y[f] + FLAKE_H) && (y + PLAYER_H > FLAKE_Y[f]);
        end
        return m;
    endfunction

    function automatic int count_bits(input logic [FLAKE_NUM-1:0] m);
        int n;
        n = 0;
        for (int i = 0; i < FLAKE_NUM; i++) begin
            n += int'(m[i]);
        end
        return n;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            mismatch_cnt_o++;
            $display("MISMATCH %s expected %h got %h at %0t", name, exp, got, $time);
        end
    endtask

    // outputs and inputs are both settled at the falling edge
    always @(negedge clk) begin
        if (!rst_n_i) begin
            brk_m          = 1'b0;
            rst_m          = 1'b0;
            held_m         = '0;
            cnt_m          = 0;
            x_m            = START_X;
            y_m            = START_Y;
            face_m         = 1'b1;
            jump_m         = 1'b0;
            jcnt_m         = 0;
            blk_m          = '0;
            blk_m[BLK_DOWN] = 1'b1;
            mask_m         = '0;
            stepped_m      = 1'b0;
            restarted_m    = 1'b0;
            x_prev         = START_X;
            y_prev         = START_Y;
            rise_run       = 0;
            mismatch_cnt_o = 0;
            other_cnt_o    = 0;
        end else begin
            check_value("pos_x_o", pos_x_i, x_m);
            check_value("pos_y_o", pos_y_i, y_m);
            check_value("airborne_o", airborne_i, !blk_m[BLK_DOWN]);
            check_value("facing_right_o", facing_right_i, face_m);
            check_value("flakes_taken_o", flakes_taken_i, mask_m);
            check_value("score_o", score_i, count_bits(mask_m));

            if (hits_ground(pos_x_i, pos_y_i)) begin
                other_cnt_o++;
                $display("player box at x %0d y %0d overlaps a ground block", pos_x_i, pos_y_i);
            end

            dx = pos_x_i - x_prev;
            dy = pos_y_i - y_prev;
            if (!stepped_m && (dx != 0 || dy != 0)) begin
                other_cnt_o++;
                $display("position moved without a step tick or restart at %0t", $time);
            end
            if (!restarted_m && ((dx != 0 && dx != 1 && dx != '1) ||
                                 (dy != 0 && dy != 1 && dy != '1))) begin
                other_cnt_o++;
                $display("position moved more than one pixel in one step at %0t", $time);
            end
            if (restarted_m) begin
                rise_run = 0;
            end else if (dy == '1) begin
                rise_run++;
                if (rise_run > JUMP_STEPS) begin
                    other_cnt_o++;
                    $display("jump kept rising past %0d steps at %0t", JUMP_STEPS, $time);
                end
            end else if (dy != 0) begin
                rise_run = 0;
            end
            x_prev = pos_x_i;
            y_prev = pos_y_i;

            // advance the model across the coming rising edge
            tick        = (cnt_m == STEP_DIV - 1);
            sides_now   = sides_at(x_m, y_m);
            stepped_m   = tick || rst_m;
            restarted_m = rst_m;
            if (rst_m) begin
                x_m    = START_X;
                y_m    = START_Y;
                jump_m = 1'b0;
                jcnt_m = 0;
            end else if (tick) begin
                if (held_m[HELD_LEFT] && !held_m[HELD_RIGHT] && !blk_m[BLK_LEFT]) begin
                    x_m    = x_m - 1'b1;
                    face_m = 1'b0;
                end else if (held_m[HELD_RIGHT] && !blk_m[BLK_RIGHT]) begin
                    x_m    = x_m + 1'b1;
                    face_m = 1'b1;
                end
                if (jump_m && (blk_m[BLK_UP] || jcnt_m == JUMP_STEPS)) begin
                    jump_m = 1'b0;
                    if (!blk_m[BLK_DOWN]) begin
                        y_m = y_m + 1'b1;
                    end
                end else if (jump_m) begin
                    y_m    = y_m - 1'b1;
                    jcnt_m = jcnt_m + 1;
                end else if (held_m[HELD_JUMP] && blk_m[BLK_DOWN]) begin
                    jump_m = 1'b1;
                    jcnt_m = 0;
                end else if (!blk_m[BLK_DOWN]) begin
                    y_m = y_m + 1'b1;
                end
            end
            cnt_m  = (rst_m || tick) ? 0 : cnt_m + 1;
            blk_m  = sides_now;
            mask_m = mask_m | flakes_under(pos_x_i, pos_y_i);

            // the break flag is consumed by any byte
            rst_m = scan_valid_i && (scan_code_i == KEY_R) && !brk_m;
            if (scan_valid_i) begin
                case (scan_code_i)
                    KEY_W: held_m[HELD_JUMP] = !brk_m;
                    KEY_A: held_m[HELD_LEFT] = !brk_m;
                    KEY_D: held_m[HELD_RIGHT] = !brk_m;
                    default: ;
                endcase
                brk_m = (scan_code_i == BREAK_PREFIX);
            end
        end
    end

    always @(posedge done_i) begin
        $display("checks finished with %0d mismatches and %0d other errors",
                 mismatch_cnt_o, other_cnt_o);
    end

endmodule

`default_nettype wire

/* dv/tb_top.sv */
`default_nettype none

module tb_top;

    timeunit 1ns;
    timeprecision 100ps;

    import world_pkg::*;
    import ctrl_pkg::*;

    localparam int RUN_CYCLES = 4000;
    localparam int CLK_PERIOD = 20;

    logic                 clk;
    logic                 rst_n_i;
    logic                 scan_valid_i;
    logic [SCAN_W-1:0]    scan_code_i;
    pos_x_t               pos_x_o;
    pos_y_t               pos_y_o;
    logic                 airborne_o;
    logic                 facing_right_o;
    logic [SCORE_W-1:0]   score_o;
    logic [FLAKE_NUM-1:0] flakes_taken_o;
    int                   mismatch_cnt;
    int                   other_cnt;
    logic                 run_done;

    logic [31:0] lfsr_state;
    logic [31:0] pick;
    int          cycle_cnt;
    logic        w_down;
    logic        a_down;
    logic        d_down;

    snow_game_top uut (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .scan_valid_i   (scan_valid_i),
        .scan_code_i    (scan_code_i),
        .pos_x_o        (pos_x_o),
        .pos_y_o        (pos_y_o),
        .airborne_o     (airborne_o),
        .facing_right_o (facing_right_o),
        .score_o        (score_o),
        .flakes_taken_o (flakes_taken_o)
    );

    game_checker chk (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .scan_valid_i   (scan_valid_i),
        .scan_code_i    (scan_code_i),
        .pos_x_i        (pos_x_o),
        .pos_y_i        (pos_y_o),
        .airborne_i     (airborne_o),
        .facing_right_i (facing_right_o),
        .score_i        (score_o),
        .flakes_taken_i (flakes_taken_o),
        .done_i         (run_done),
        .mismatch_cnt_o (mismatch_cnt),
        .other_cnt_o    (other_cnt)
    );

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] bits);
        bits = '0;
        repeat (n) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits = {bits[30:0], lfsr_state[0]};
        end
    endtask

    // one byte slot with inputs changing 2 ns after the edge
    task automatic drive_cycle(input logic valid, input logic [SCAN_W-1:0] code);
        scan_valid_i = valid;
        scan_code_i  = code;
        @(posedge clk);
        #2;
        cycle_cnt++;
    endtask

    task automatic send_key(input logic [SCAN_W-1:0] code, input logic is_break);
        if (is_break) begin
            drive_cycle(1'b1, BREAK_PREFIX);
        end
        drive_cycle(1'b1, code);
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(RUN_CYCLES * CLK_PERIOD + 2000);
        $display("watchdog expired before the stimulus finished");
        $display("Done: errors found");
        $finish;
    end

    initial begin
        rst_n_i      = 1'b0;
        scan_valid_i = 1'b0;
        scan_code_i  = '0;
        run_done     = 1'b0;
        lfsr_state   = 32'h057e_6051;
        cycle_cnt    = 0;
        w_down       = 1'b0;
        a_down       = 1'b0;
        d_down       = 1'b0;
        repeat (3) @(posedge clk);
        #2 rst_n_i = 1'b1;

        while (cycle_cnt < RUN_CYCLES) begin
            take_bits(4, pick);
            case (pick[3:0])
                4'd0, 4'd1, 4'd2: begin
                    send_key(KEY_W, w_down);
                    w_down = !w_down;
                end
                4'd3, 4'd4, 4'd5, 4'd6: begin
                    if (a_down || pos_x_o >= 24) begin
                        send_key(KEY_A, a_down);
                        a_down = !a_down;
                    end
                end
                4'd7, 4'd8, 4'd9, 4'd10: begin
                    send_key(KEY_D, d_down);
                    d_down = !d_down;
                end
                4'd11: begin
                    send_key(KEY_R, 1'b0);
                    send_key(KEY_R, 1'b1);
                end
                4'd12: begin
                    // junk codes in 80..BF that sometimes follow a break prefix
                    take_bits(7, pick);
                    if (pick[6]) begin
                        drive_cycle(1'b1, BREAK_PREFIX);
                    end
                    drive_cycle(1'b1, {2'b10, pick[5:0]});
                end
                default: begin
                    take_bits(4, pick);
                    repeat (pick[3:0]) drive_cycle(1'b0, '0);
                end
            endcase
            // x would wrap below zero at the left edge
            if (a_down && pos_x_o < 16) begin
                send_key(KEY_A, 1'b1);
                a_down = 1'b0;
            end
        end

        scan_valid_i = 1'b0;
        run_done     = 1'b1;
        #1;
        if (mismatch_cnt == 0 && other_cnt == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
logic/world_pkg.sv
logic/ctrl_pkg.sv
logic/key_decoder.sv
logic/ground_collide.sv
logic/player_motion.sv
logic/flake_collect.sv
logic/snow_game_top.sv
dv/game_checker.sv
dv/tb_top.sv
